//--- vec_top.f
+incdir+.
vec_pkg.sv
vec_dispatcher.sv
vec_sequencer.sv
vec_lane.sv
vec_redu.sv
vec_top.sv
tb_vec_top.sv

//--- run.sh
#!/bin/sh
# Build and run the vec_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_vec_top -f vec_top.f; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_vec_top 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- tb_vec_tests.svh
`ifndef TB_VEC_TESTS_SVH
`define TB_VEC_TESTS_SVH

////////////////////////////////////////////////////////////
// Instruction encoding and core port handshakes
////////////////////////////////////////////////////////////

function automatic vec_pkg::vec_insn_u make_cfg(input logic [15:0] avl);
  vec_pkg::vec_insn_u insn;
  insn         = '0;
  insn.cfg.op  = vec_pkg::OP_SETVL;
  insn.cfg.avl = avl;
  return insn;
endfunction

function automatic vec_pkg::vec_insn_u make_arith(input vec_pkg::vec_op_e op,
                                                  input logic [`VEC_REG_W-1:0] vd,
                                                  input logic [`VEC_REG_W-1:0] vs1,
                                                  input logic [`VEC_REG_W-1:0] vs2,
                                                  input logic [`VEC_ELEN-1:0] scalar);
  vec_pkg::vec_insn_u insn;
  insn              = '0;
  insn.arith.op     = op;
  insn.arith.vd     = vd;
  insn.arith.vs1    = vs1;
  insn.arith.vs2    = vs2;
  insn.arith.scalar = scalar;
  return insn;
endfunction

// Called on a falling edge; returns on a falling edge
task automatic issue_insn(input vec_pkg::vec_insn_u insn, input int stall,
                          output logic [`VEC_ELEN-1:0] data);
  acc_req_valid_i = 1'b1;
  acc_insn_i      = insn;
  while (!acc_req_ready_o) @(negedge clk_i);
  @(negedge clk_i);
  acc_req_valid_i = 1'b0;
  acc_insn_i      = '0;

  resp_wait = 0;
  while (!acc_resp_valid_o) begin
    @(negedge clk_i);
    resp_wait++;
  end
  data = acc_resp_data_o;
  // Dispatcher still holds the instruction
  check("vec_idle_o", 16'(vec_idle_o), 16'd0);
  // No new request while a response is pending
  check("acc_req_ready_o", 16'(acc_req_ready_o), 16'd0);

  // Held response must not move
  repeat (stall) begin
    @(negedge clk_i);
    check("acc_resp_valid_o", 16'(acc_resp_valid_o), 16'd1);
    check("acc_resp_data_o", acc_resp_data_o, data);
  end
  acc_resp_ready_i = 1'b1;
  @(negedge clk_i);
  acc_resp_ready_i = 1'b0;
endtask

task automatic set_length(input int avl, input int stall);
  logic [`VEC_ELEN-1:0] data;
  int                   exp_vl;
  exp_vl = (avl > `VEC_VLMAX) ? `VEC_VLMAX : avl;
  issue_insn(make_cfg(16'(avl)), stall, data);
  check("acc_resp_data_o", data, 16'(exp_vl));
  // setvl answers in the cycle after acceptance
  check("acc_resp_valid_o delay", 16'(resp_wait), 16'd0);
  model_vl = exp_vl;
endtask

// Updates the model, issues, and checks the response word
task automatic exec_arith(input vec_pkg::vec_op_e op, input logic [`VEC_REG_W-1:0] vd,
                          input logic [`VEC_REG_W-1:0] vs1,
                          input logic [`VEC_REG_W-1:0] vs2,
                          input logic [`VEC_ELEN-1:0] scalar, input int stall,
                          output logic [`VEC_ELEN-1:0] data);
  logic [`VEC_ELEN-1:0] exp;
  logic [`VEC_ELEN-1:0] a;
  logic [`VEC_ELEN-1:0] b;
  exp = 16'd0;
  for (int i = 0; i < model_vl; i++) begin
    a = vrf_model[vs2][i];
    b = vrf_model[vs1][i];
    case (op)
      vec_pkg::OP_REDSUM: exp = exp + a;
      vec_pkg::OP_MV_VX:  vrf_model[vd][i] = scalar;
      vec_pkg::OP_VID:    vrf_model[vd][i] = 16'(i);
      vec_pkg::OP_ADD_VV: vrf_model[vd][i] = a + b;
      vec_pkg::OP_SUB_VV: vrf_model[vd][i] = a - b;
      vec_pkg::OP_AND_VV: vrf_model[vd][i] = a & b;
      vec_pkg::OP_ADD_VX: vrf_model[vd][i] = a + scalar;
      default:            vrf_model[vd][i] = a;
    endcase
  end
  issue_insn(make_arith(op, vd, vs1, vs2, scalar), stall, data);
  check("acc_resp_data_o", data, exp);
endtask

task automatic wait_idle();
  int cycles;
  cycles = 0;
  while (!vec_idle_o && cycles < 4 * `VEC_ELEMS_PER_LANE) begin
    @(negedge clk_i);
    cycles++;
  end
  check("vec_idle_o", 16'(vec_idle_o), 16'd1);
endtask

////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////

task automatic reset_and_setvl();
  int avl;
  check("vec_idle_o", 16'(vec_idle_o), 16'd1);
  check("acc_resp_valid_o", 16'(acc_resp_valid_o), 16'd0);
  set_length(0, 0);
  set_length(16, 0);
  set_length(17, 1);
  set_length(65535, 0);
  set_length(5, 0);
  repeat (5) begin
    avl = int'($urandom_range(0, 40));
    set_length(avl, 0);
  end
endtask

task automatic broadcast_and_vid();
  logic [`VEC_ELEN-1:0] s;
  logic [`VEC_ELEN-1:0] data;
  s = 16'($urandom);
  set_length(16, 0);
  exec_arith(vec_pkg::OP_MV_VX, 3'd1, 3'd0, 3'd0, s, 0, data);
  exec_arith(vec_pkg::OP_REDSUM, 3'd0, 3'd0, 3'd1, 16'd0, 0, data);
  check("acc_resp_data_o", data, 16'(s * 16));
  exec_arith(vec_pkg::OP_VID, 3'd2, 3'd0, 3'd0, 16'd0, 0, data);
  exec_arith(vec_pkg::OP_REDSUM, 3'd0, 3'd0, 3'd2, 16'd0, 0, data);
  // 0 + 1 + ... + 15
  check("acc_resp_data_o", data, 16'd120);
endtask

task automatic vv_ops();
  logic [`VEC_ELEN-1:0] a;
  logic [`VEC_ELEN-1:0] b;
  logic [`VEC_ELEN-1:0] data;
  a = 16'($urandom);
  b = 16'($urandom);
  set_length(16, 0);
  exec_arith(vec_pkg::OP_MV_VX, 3'd3, 3'd0, 3'd0, a, 0, data);
  // v4 is index plus b, so its elements differ
  exec_arith(vec_pkg::OP_ADD_VX, 3'd4, 3'd0, 3'd2, b, 0, data);
  exec_arith(vec_pkg::OP_ADD_VV, 3'd5, 3'd3, 3'd4, 16'd0, 0, data);
  exec_arith(vec_pkg::OP_SUB_VV, 3'd6, 3'd3, 3'd4, 16'd0, 0, data);
  exec_arith(vec_pkg::OP_AND_VV, 3'd7, 3'd3, 3'd4, 16'd0, 0, data);
  exec_arith(vec_pkg::OP_REDSUM, 3'd0, 3'd0, 3'd5, 16'd0, 0, data);
  exec_arith(vec_pkg::OP_REDSUM, 3'd0, 3'd0, 3'd6, 16'd0, 0, data);
  exec_arith(vec_pkg::OP_REDSUM, 3'd0, 3'd0, 3'd7, 16'd0, 0, data);
endtask

task automatic partial_vl_tail();
  logic [`VEC_ELEN-1:0] s0;
  logic [`VEC_ELEN-1:0] s1;
  logic [`VEC_ELEN-1:0] data;
  s0 = 16'($urandom);
  s1 = 16'($urandom);
  set_length(16, 0);
  exec_arith(vec_pkg::OP_MV_VX, 3'd1, 3'd0, 3'd0, s0, 0, data);
  set_length(7, 0);
  exec_arith(vec_pkg::OP_ADD_VX, 3'd1, 3'd0, 3'd1, s1, 0, data);
  exec_arith(vec_pkg::OP_REDSUM, 3'd0, 3'd0, 3'd1, 16'd0, 0, data);
  set_length(16, 0);
  exec_arith(vec_pkg::OP_REDSUM, 3'd0, 3'd0, 3'd1, 16'd0, 0, data);
  // Seven updated elements and nine untouched ones
  check("acc_resp_data_o", data, 16'(7 * (s0 + s1) + 9 * s0));
  set_length(0, 0);
  exec_arith(vec_pkg::OP_REDSUM, 3'd0, 3'd0, 3'd1, 16'd0, 0, data);
  check("acc_resp_data_o", data, 16'd0);
endtask

task automatic stalled_responses();
  logic [`VEC_ELEN-1:0] data;
  int                   stall;
  set_length(16, 3);
  for (int k = 0; k < 4; k++) begin
    stall = int'($urandom_range(1, 6));
    exec_arith(vec_pkg::OP_ADD_VV, 3'd0, 3'd5, (k == 0) ? 3'd6 : 3'd0, 16'd0, stall, data);
    stall = int'($urandom_range(1, 6));
    exec_arith(vec_pkg::OP_REDSUM, 3'd0, 3'd0, 3'd0, 16'd0, stall, data);
  end
  wait_idle();
endtask

`endif

//--- tb_vec_top.sv
`timescale 1ns/1ps
`include "vec_consts.svh"

module tb_vec_top;

  localparam int ClkPeriod     = 100;
  localparam int CyclesPerInsn = 200;
  // Instructions issued by all directed tests together
  localparam int PlannedInsns  = 42;

  logic                 clk_i;
  logic                 rst_i;
  logic                 acc_req_valid_i;
  logic                 acc_req_ready_o;
  vec_pkg::vec_insn_u   acc_insn_i;
  logic                 acc_resp_valid_o;
  logic                 acc_resp_ready_i;
  logic [`VEC_ELEN-1:0] acc_resp_data_o;
  logic                 vec_idle_o;

  // Reference register file indexed by element number
  logic [`VEC_ELEN-1:0] vrf_model [`VEC_NR_VREGS][`VEC_VLMAX];
  int                   model_vl;
  // Cycles between request transfer and response valid
  int                   resp_wait;

  vec_top UUT (
    .clk_i            (clk_i           ),
    .rst_i            (rst_i           ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_insn_i       (acc_insn_i      ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i),
    .acc_resp_data_o  (acc_resp_data_o ),
    .vec_idle_o       (vec_idle_o      )
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Compare and watchdog
  ////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [`VEC_ELEN-1:0] got,
                       input logic [`VEC_ELEN-1:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s = 0x%04h, expected 0x%04h", $time, name, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Budget of cycles per instruction over the whole run
  initial begin
    #(PlannedInsns * CyclesPerInsn * ClkPeriod);
    $display("Watchdog expired: the tests did not finish in time");
    $display("*** FAILED ***");
    $fatal(1, "Timeout");
  end

  `include "tb_vec_tests.svh"

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_i            = 1'b1;
    acc_req_valid_i  = 1'b0;
    acc_insn_i       = '0;
    acc_resp_ready_i = 1'b0;
    model_vl         = 0;
    resp_wait        = 0;
    void'($urandom(32'h34d95283));

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    reset_and_setvl();
    broadcast_and_vid();
    vv_ops();
    partial_vl_tail();
    stalled_responses();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- vec_top.sv
`timescale 1ns/1ps
`include "vec_consts.svh"

module vec_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Core port
  input  logic                 acc_req_valid_i,
  output logic                 acc_req_ready_o,
  input  vec_pkg::vec_insn_u   acc_insn_i,
  output logic                 acc_resp_valid_o,
  input  logic                 acc_resp_ready_i,
  output logic [`VEC_ELEN-1:0] acc_resp_data_o,
  output logic                 vec_idle_o
);

  ////////////////////////////////////////////////////////////
  // Dispatcher
  ////////////////////////////////////////////////////////////

  logic                  seq_valid;
  logic                  seq_ready;
  vec_pkg::vec_op_e      seq_op;
  logic [`VEC_REG_W-1:0] seq_vd;
  logic [`VEC_REG_W-1:0] seq_vs1;
  logic [`VEC_REG_W-1:0] seq_vs2;
  logic [`VEC_ELEN-1:0]  seq_scalar;
  logic [`VEC_VL_W-1:0]  seq_vl;
  logic                  red_valid;
  logic [`VEC_ELEN-1:0]  red_sum;
  logic                  disp_idle;

  vec_dispatcher i_dispatcher (
    .clk_i            (clk_i           ),
    .rst_i            (rst_i           ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_insn_i       (acc_insn_i      ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i),
    .acc_resp_data_o  (acc_resp_data_o ),
    .seq_valid_o      (seq_valid       ),
    .seq_ready_i      (seq_ready       ),
    .seq_op_o         (seq_op          ),
    .seq_vd_o         (seq_vd          ),
    .seq_vs1_o        (seq_vs1         ),
    .seq_vs2_o        (seq_vs2         ),
    .seq_scalar_o     (seq_scalar      ),
    .seq_vl_o         (seq_vl          ),
    .red_valid_i      (red_valid       ),
    .red_sum_i        (red_sum         ),
    .disp_idle_o      (disp_idle       )
  );

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  logic                     pe_valid;
  vec_pkg::vec_op_e         pe_op;
  logic [`VEC_REG_W-1:0]    pe_vd;
  logic [`VEC_REG_W-1:0]    pe_vs1;
  logic [`VEC_REG_W-1:0]    pe_vs2;
  logic [`VEC_ELEN-1:0]     pe_scalar;
  logic [`VEC_VL_W-1:0]     pe_vl;
  logic [`VEC_NR_LANES-1:0] lane_done;

  vec_sequencer i_sequencer (
    .clk_i        (clk_i     ),
    .rst_i        (rst_i     ),
    .seq_valid_i  (seq_valid ),
    .seq_ready_o  (seq_ready ),
    .seq_op_i     (seq_op    ),
    .seq_vd_i     (seq_vd    ),
    .seq_vs1_i    (seq_vs1   ),
    .seq_vs2_i    (seq_vs2   ),
    .seq_scalar_i (seq_scalar),
    .seq_vl_i     (seq_vl    ),
    .disp_idle_i  (disp_idle ),
    .pe_valid_o   (pe_valid  ),
    .pe_op_o      (pe_op     ),
    .pe_vd_o      (pe_vd     ),
    .pe_vs1_o     (pe_vs1    ),
    .pe_vs2_o     (pe_vs2    ),
    .pe_scalar_o  (pe_scalar ),
    .pe_vl_o      (pe_vl     ),
    .lane_done_i  (lane_done ),
    .vec_idle_o   (vec_idle_o)
  );

  ////////////////////////////////////////////////////////////
  // Lanes and reduction
  ////////////////////////////////////////////////////////////

  logic [`VEC_NR_LANES-1:0]                partial_valid;
  logic [`VEC_NR_LANES-1:0][`VEC_ELEN-1:0] partial_sum;

  for (genvar lane = 0; lane < `VEC_NR_LANES; lane++) begin : gen_lanes
    vec_lane #(
      .LaneId (lane)
    ) i_lane (
      .clk_i           (clk_i               ),
      .rst_i           (rst_i               ),
      .pe_valid_i      (pe_valid            ),
      .pe_op_i         (pe_op               ),
      .pe_vd_i         (pe_vd               ),
      .pe_vs1_i        (pe_vs1              ),
      .pe_vs2_i        (pe_vs2              ),
      .pe_scalar_i     (pe_scalar           ),
      .pe_vl_i         (pe_vl               ),
      .lane_done_o     (lane_done[lane]     ),
      .partial_valid_o (partial_valid[lane] ),
      .partial_sum_o   (partial_sum[lane]   )
    );
  end : gen_lanes

  vec_redu i_redu (
    .clk_i           (clk_i        ),
    .rst_i           (rst_i        ),
    .partial_valid_i (partial_valid),
    .partial_sum_i   (partial_sum  ),
    .red_valid_o     (red_valid    ),
    .red_sum_o       (red_sum      )
  );

endmodule

//--- vec_redu.sv
`timescale 1ns/1ps
`include "vec_consts.svh"

module vec_redu (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  // Lanes
  input  logic [`VEC_NR_LANES-1:0]                partial_valid_i,
  input  logic [`VEC_NR_LANES-1:0][`VEC_ELEN-1:0] partial_sum_i,
  // Dispatcher
  output logic                                    red_valid_o,
  output logic [`VEC_ELEN-1:0]                    red_sum_o
);

  logic [`VEC_NR_LANES-1:0]                have_q;
  logic [`VEC_NR_LANES-1:0][`VEC_ELEN-1:0] sum_q;
  logic [`VEC_ELEN-1:0]                    total;
  logic                                    all_in;
  logic                                    red_valid_q;
  logic [`VEC_ELEN-1:0]                    red_sum_q;

  assign all_in = &have_q;

  // Wrapping sum of the stored partials
  always_comb begin
    total = '0;
    for (int i = 0; i < `VEC_NR_LANES; i++) begin
      total = total + sum_q[i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      have_q      <= '0;
      red_valid_q <= 1'b0;
    end else begin
      red_valid_q <= all_in;
      if (all_in) begin
        have_q <= '0;
      end else begin
        have_q <= have_q | partial_valid_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `VEC_NR_LANES; i++) begin
      if (partial_valid_i[i]) sum_q[i] <= partial_sum_i[i];
    end
    if (all_in) red_sum_q <= total;
  end

  assign red_valid_o = red_valid_q;
  assign red_sum_o   = red_sum_q;

  // A lane reports once per reduction
  assert property (@(posedge clk_i) disable iff (rst_i) (partial_valid_i & have_q) == '0);

endmodule

//--- vec_lane.sv
`timescale 1ns/1ps
`include "vec_consts.svh"

module vec_lane #(
  parameter int unsigned LaneId = 0
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Sequencer
  input  logic                  pe_valid_i,
  input  vec_pkg::vec_op_e      pe_op_i,
  input  logic [`VEC_REG_W-1:0] pe_vd_i,
  input  logic [`VEC_REG_W-1:0] pe_vs1_i,
  input  logic [`VEC_REG_W-1:0] pe_vs2_i,
  input  logic [`VEC_ELEN-1:0]  pe_scalar_i,
  input  logic [`VEC_VL_W-1:0]  pe_vl_i,
  output logic                  lane_done_o,
  // Reduction unit
  output logic                  partial_valid_o,
  output logic [`VEC_ELEN-1:0]  partial_sum_o
);

  localparam int unsigned SlotW    = $clog2(`VEC_ELEMS_PER_LANE + 1);
  localparam int unsigned SlotIdxW = $clog2(`VEC_ELEMS_PER_LANE);

  ////////////////////////////////////////////////////////////
  // Register slice and control
  ////////////////////////////////////////////////////////////

  logic [`VEC_ELEN-1:0]  vrf_q [`VEC_NR_VREGS][`VEC_ELEMS_PER_LANE];
  logic                  busy_q;
  logic [SlotW-1:0]      slot_q;
  logic [SlotW-1:0]      nslots_q;
  logic [SlotW-1:0]      nslots_d;
  logic                  partial_valid_q;
  logic [`VEC_ELEN-1:0]  acc_q;
  vec_pkg::vec_op_e      op_q;
  logic [`VEC_REG_W-1:0] vd_q;
  logic [`VEC_REG_W-1:0] vs1_q;
  logic [`VEC_REG_W-1:0] vs2_q;
  logic [`VEC_ELEN-1:0]  scalar_q;
  logic                  step;
  logic [SlotIdxW-1:0]   slot_idx;
  logic [`VEC_ELEN-1:0]  opa;
  logic [`VEC_ELEN-1:0]  opb;
  logic [`VEC_ELEN-1:0]  elem_idx;
  logic [`VEC_ELEN-1:0]  result;

  // Elements LaneId, LaneId+lanes, ... below vl belong here
  assign nslots_d = SlotW'((int'(pe_vl_i) + `VEC_NR_LANES - 1 - LaneId) / `VEC_NR_LANES);

  assign step     = busy_q && (slot_q < nslots_q);
  assign slot_idx = slot_q[SlotIdxW-1:0];
  assign elem_idx = `VEC_ELEN'(slot_q * `VEC_NR_LANES + LaneId);

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  // opa from vs2, opb from vs1; subtract is vs2 - vs1
  assign opa = vrf_q[vs2_q][slot_idx];
  assign opb = vrf_q[vs1_q][slot_idx];

  always_comb begin
    case (op_q)
      vec_pkg::OP_MV_VX:  result = scalar_q;
      vec_pkg::OP_VID:    result = elem_idx;
      vec_pkg::OP_ADD_VV: result = opa + opb;
      vec_pkg::OP_SUB_VV: result = opa - opb;
      vec_pkg::OP_AND_VV: result = opa & opb;
      vec_pkg::OP_ADD_VX: result = opa + scalar_q;
      default:            result = opa;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q          <= 1'b0;
      slot_q          <= '0;
      nslots_q        <= '0;
      partial_valid_q <= 1'b0;
    end else begin
      partial_valid_q <= 1'b0;
      if (pe_valid_i) begin
        busy_q   <= 1'b1;
        slot_q   <= '0;
        nslots_q <= nslots_d;
      end else if (step) begin
        slot_q <= slot_q + 1'b1;
      end else if (busy_q) begin
        // Last slot done, partial goes out even with no active slots
        busy_q          <= 1'b0;
        partial_valid_q <= (op_q == vec_pkg::OP_REDSUM);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pe_valid_i) begin
      op_q     <= pe_op_i;
      vd_q     <= pe_vd_i;
      vs1_q    <= pe_vs1_i;
      vs2_q    <= pe_vs2_i;
      scalar_q <= pe_scalar_i;
      acc_q    <= '0;
    end else if (step) begin
      if (op_q == vec_pkg::OP_REDSUM) begin
        acc_q <= acc_q + opa;
      end else begin
        vrf_q[vd_q][slot_idx] <= result;
      end
    end
  end

  assign lane_done_o     = !busy_q;
  assign partial_valid_o = partial_valid_q;
  assign partial_sum_o   = acc_q;

  // Sequencer never overlaps instructions in a lane
  assert property (@(posedge clk_i) disable iff (rst_i) pe_valid_i |-> !busy_q);

endmodule

//--- vec_sequencer.sv
`timescale 1ns/1ps
`include "vec_consts.svh"

module vec_sequencer (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // Dispatcher
  input  logic                     seq_valid_i,
  output logic                     seq_ready_o,
  input  vec_pkg::vec_op_e         seq_op_i,
  input  logic [`VEC_REG_W-1:0]    seq_vd_i,
  input  logic [`VEC_REG_W-1:0]    seq_vs1_i,
  input  logic [`VEC_REG_W-1:0]    seq_vs2_i,
  input  logic [`VEC_ELEN-1:0]     seq_scalar_i,
  input  logic [`VEC_VL_W-1:0]     seq_vl_i,
  input  logic                     disp_idle_i,
  // Lanes
  output logic                     pe_valid_o,
  output vec_pkg::vec_op_e         pe_op_o,
  output logic [`VEC_REG_W-1:0]    pe_vd_o,
  output logic [`VEC_REG_W-1:0]    pe_vs1_o,
  output logic [`VEC_REG_W-1:0]    pe_vs2_o,
  output logic [`VEC_ELEN-1:0]     pe_scalar_o,
  output logic [`VEC_VL_W-1:0]     pe_vl_o,
  input  logic [`VEC_NR_LANES-1:0] lane_done_i,
  output logic                     vec_idle_o
);

  logic                  busy_q;
  logic                  pe_valid_q;
  logic                  accept;
  logic                  all_done;
  vec_pkg::vec_op_e      op_q;
  logic [`VEC_REG_W-1:0] vd_q;
  logic [`VEC_REG_W-1:0] vs1_q;
  logic [`VEC_REG_W-1:0] vs2_q;
  logic [`VEC_ELEN-1:0]  scalar_q;
  logic [`VEC_VL_W-1:0]  vl_q;

  assign all_done    = &lane_done_i;
  assign seq_ready_o = !busy_q && all_done;
  assign accept      = seq_valid_i && seq_ready_o;

  // Lanes only drop done the cycle after the broadcast,
  // so the pulse cycle itself must not end the instruction
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q     <= 1'b0;
      pe_valid_q <= 1'b0;
    end else begin
      pe_valid_q <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (busy_q && !pe_valid_q && all_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q     <= seq_op_i;
      vd_q     <= seq_vd_i;
      vs1_q    <= seq_vs1_i;
      vs2_q    <= seq_vs2_i;
      scalar_q <= seq_scalar_i;
      vl_q     <= seq_vl_i;
    end
  end

  assign pe_valid_o  = pe_valid_q;
  assign pe_op_o     = op_q;
  assign pe_vd_o     = vd_q;
  assign pe_vs1_o    = vs1_q;
  assign pe_vs2_o    = vs2_q;
  assign pe_scalar_o = scalar_q;
  assign pe_vl_o     = vl_q;

  assign vec_idle_o = disp_idle_i && !busy_q;

  // Broadcast only reaches lanes that are all idle
  assert property (@(posedge clk_i) disable iff (rst_i) pe_valid_o |-> all_done);

endmodule

//--- vec_dispatcher.sv
`timescale 1ns/1ps
`include "vec_consts.svh"

module vec_dispatcher (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Core request
  input  logic                  acc_req_valid_i,
  output logic                  acc_req_ready_o,
  input  vec_pkg::vec_insn_u    acc_insn_i,
  // Core response
  output logic                  acc_resp_valid_o,
  input  logic                  acc_resp_ready_i,
  output logic [`VEC_ELEN-1:0]  acc_resp_data_o,
  // Sequencer
  output logic                  seq_valid_o,
  input  logic                  seq_ready_i,
  output vec_pkg::vec_op_e      seq_op_o,
  output logic [`VEC_REG_W-1:0] seq_vd_o,
  output logic [`VEC_REG_W-1:0] seq_vs1_o,
  output logic [`VEC_REG_W-1:0] seq_vs2_o,
  output logic [`VEC_ELEN-1:0]  seq_scalar_o,
  output logic [`VEC_VL_W-1:0]  seq_vl_o,
  // Reduction unit
  input  logic                  red_valid_i,
  input  logic [`VEC_ELEN-1:0]  red_sum_i,
  output logic                  disp_idle_o
);

  localparam logic [1:0] StIdle    = 2'd0;
  localparam logic [1:0] StIssue   = 2'd1;
  localparam logic [1:0] StWaitRed = 2'd2;
  localparam logic [1:0] StResp    = 2'd3;

  logic [1:0]            state_q;
  logic [`VEC_VL_W-1:0]  vl_q;
  logic [`VEC_VL_W-1:0]  new_vl;
  logic [`VEC_ELEN-1:0]  resp_data_q;
  logic                  accept;
  logic                  is_setvl;
  vec_pkg::vec_op_e      op_q;
  logic [`VEC_REG_W-1:0] vd_q;
  logic [`VEC_REG_W-1:0] vs1_q;
  logic [`VEC_REG_W-1:0] vs2_q;
  logic [`VEC_ELEN-1:0]  scalar_q;

  assign accept   = acc_req_valid_i && acc_req_ready_o;
  assign is_setvl = (acc_insn_i.cfg.op == vec_pkg::OP_SETVL);

  // Clamp the requested length to VLMAX
  assign new_vl = (acc_insn_i.cfg.avl > `VEC_VLMAX) ? `VEC_VL_W'(`VEC_VLMAX)
                                                    : acc_insn_i.cfg.avl[`VEC_VL_W-1:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= StIdle;
      vl_q    <= '0;
    end else begin
      case (state_q)
        StIdle: begin
          if (accept) begin
            if (is_setvl) begin
              vl_q    <= new_vl;
              state_q <= StResp;
            end else begin
              state_q <= StIssue;
            end
          end
        end
        StIssue: begin
          if (seq_ready_i) begin
            state_q <= (op_q == vec_pkg::OP_REDSUM) ? StWaitRed : StResp;
          end
        end
        StWaitRed: begin
          if (red_valid_i) state_q <= StResp;
        end
        default: begin
          if (acc_resp_ready_i) state_q <= StIdle;
        end
      endcase
    end
  end

  // Instruction fields and response word
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q        <= acc_insn_i.arith.op;
      vd_q        <= acc_insn_i.arith.vd;
      vs1_q       <= acc_insn_i.arith.vs1;
      vs2_q       <= acc_insn_i.arith.vs2;
      scalar_q    <= acc_insn_i.arith.scalar;
      resp_data_q <= is_setvl ? `VEC_ELEN'(new_vl) : '0;
    end else if (state_q == StWaitRed && red_valid_i) begin
      resp_data_q <= red_sum_i;
    end
  end

  assign acc_req_ready_o  = (state_q == StIdle);
  assign acc_resp_valid_o = (state_q == StResp);
  assign acc_resp_data_o  = resp_data_q;
  assign disp_idle_o      = (state_q == StIdle);

  assign seq_valid_o  = (state_q == StIssue);
  assign seq_op_o     = op_q;
  assign seq_vd_o     = vd_q;
  assign seq_vs1_o    = vs1_q;
  assign seq_vs2_o    = vs2_q;
  assign seq_scalar_o = scalar_q;
  assign seq_vl_o     = vl_q;

  // Stalled response holds its data
  assert property (@(posedge clk_i) disable iff (rst_i)
    acc_resp_valid_o && !acc_resp_ready_i |=> acc_resp_valid_o && $stable(acc_resp_data_o));

endmodule

//--- vec_pkg.sv
`include "vec_consts.svh"

package vec_pkg;

  // Vector opcodes
  typedef enum logic [3:0] {
    OP_SETVL  = 4'd0,
    OP_MV_VX  = 4'd1,
    OP_VID    = 4'd2,
    OP_ADD_VV = 4'd3,
    OP_SUB_VV = 4'd4,
    OP_AND_VV = 4'd5,
    OP_ADD_VX = 4'd6,
    OP_REDSUM = 4'd7
  } vec_op_e;

  // Instruction word, seen either as arithmetic or as configuration.
  // The opcode occupies the top nibble in both views.
  typedef union packed {
    struct packed {
      vec_op_e               op;
      logic [`VEC_REG_W-1:0] vd;
      logic [`VEC_REG_W-1:0] vs1;
      logic [`VEC_REG_W-1:0] vs2;
      logic [2:0]            pad;
      logic [`VEC_ELEN-1:0]  scalar;
    } arith;
    struct packed {
      vec_op_e               op;
      logic [11:0]           pad;
      // Requested vector length
      logic [15:0]           avl;
    } cfg;
  } vec_insn_u;

endpackage

//--- vec_consts.svh
`ifndef VEC_CONSTS_SVH
`define VEC_CONSTS_SVH

// Lane and register file geometry
`define VEC_NR_LANES 4
`define VEC_NR_VREGS 8

// Element width in bits
`define VEC_ELEN 16

// Longest vector, and the share of it held by each lane
`define VEC_VLMAX 16
`define VEC_ELEMS_PER_LANE (`VEC_VLMAX / `VEC_NR_LANES)

// Width of a vl value, 0 to VLMAX inclusive
`define VEC_VL_W 5

// Width of a vector register index
`define VEC_REG_W 3

`endif
